// ==== include/pi1r_params.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PerInt sizing and memory map for the scratch-memory subsystem
// every address here is a word address, byte address = word address * 4
// bank count and bank words must be powers of two, bank count at least 2
// PI1R_FIRSTADDR must sit on a bank boundary (multiple of PI1R_BANKWORDS)
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PI1R_PARAMS_SVH
`define PI1R_PARAMS_SVH

// data word width, one select bit per byte lane
`define PI1R_ARCHBITSZ 32
`define PI1R_SELBITSZ (`PI1R_ARCHBITSZ/8)

// byte offset bits are dropped from the bus address
`define PI1R_ADDRBITSZ 30

// identical scratch banks behind the decoder
`define PI1R_BANKCOUNT 4
// 4 KB per bank
`define PI1R_BANKWORDS 1024

// bank 0 starts at byte 0x1000
`define PI1R_FIRSTADDR 'h400
// last mapped word, anything past it hits the default slave
`define PI1R_LASTADDR (`PI1R_FIRSTADDR + (`PI1R_BANKCOUNT * `PI1R_BANKWORDS) - 1)

// field widths of the decoded-address union
`define PI1R_OFFSETBITSZ $clog2(`PI1R_BANKWORDS)
`define PI1R_BANKBITSZ $clog2(`PI1R_BANKCOUNT)
`define PI1R_UPPERBITSZ (`PI1R_ADDRBITSZ - `PI1R_BANKBITSZ - `PI1R_OFFSETBITSZ)

`endif

// ==== design/pi1r_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PerInt bus types shared by the decoder, the banks and the collector
// op encoding follows PerInt: 0 none, 1 write, 2 read, 3 read-write
// widths come from pi1r_params.svh, include path must reach include/
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "pi1r_params.svh"

package pi1r_pkg;

	// RDWR is a swap, old word out and new bytes in
	typedef enum logic [1:0] {
		NONE  = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10,
		RDWR  = 2'b11
	} pi1_op_t;

	// master to slave, held by the master until accepted
	typedef struct packed {
		pi1_op_t                      op;
		logic [`PI1R_ADDRBITSZ-1:0]   addr;
		logic [`PI1R_ARCHBITSZ-1:0]   data;
		logic [`PI1R_SELBITSZ-1:0]    sel;
	} pi1_req_t;

	// slave to master
	// rdy is a level, high when a new operation can be taken
	typedef struct packed {
		logic [`PI1R_ARCHBITSZ-1:0]   data;
		logic                         rdy;
	} pi1_rsp_t;

	// word address split into upper bits, bank select and word offset
	typedef struct packed {
		logic [`PI1R_UPPERBITSZ-1:0]  upper;
		logic [`PI1R_BANKBITSZ-1:0]   bank;
		logic [`PI1R_OFFSETBITSZ-1:0] offset;
	} pi1_addr_field_t;

	// flat view for range compares, field view for slicing
	typedef union packed {
		logic [`PI1R_ADDRBITSZ-1:0]   flat;
		pi1_addr_field_t              field;
	} pi1_addr_u;

	// handed from decoder to collector for every finished operation
	typedef struct packed {
		logic                         rd;
		logic [`PI1R_BANKBITSZ-1:0]   bank;
		logic                         dflt;
	} pi1_tag_t;

endpackage

`default_nettype wire

// ==== design/pi1r_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-master PerInt decoder with one registered request stage
// an operation is taken on a rising edge where rdy_o is high and op is set
// unmapped addresses go to a built-in default slave: writes are dropped,
// reads return zero and err_o pulses for one cycle
// the stage stalls while the selected bank holds its rdy low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "pi1r_params.svh"

module pi1r_decode import pi1r_pkg::*; (
	input  wire logic     clk_i,
	input  wire logic     rst_n_i,
	input  wire pi1_req_t req_i,
	input  wire pi1_rsp_t bank_rsp_i [`PI1R_BANKCOUNT],
	output pi1_req_t      bank_req_o [`PI1R_BANKCOUNT],
	output pi1_tag_t      tag_o,
	output logic          tag_vld_o,
	output logic          rdy_o,
	output logic          err_o
);

localparam int NB = `PI1R_BANKCOUNT;
localparam int BW = `PI1R_BANKBITSZ;

// map bounds as word addresses of bus width
localparam logic [`PI1R_ADDRBITSZ-1:0] FIRSTADDR = `PI1R_ADDRBITSZ'(`PI1R_FIRSTADDR);
localparam logic [`PI1R_ADDRBITSZ-1:0] LASTADDR = `PI1R_ADDRBITSZ'(`PI1R_LASTADDR);
// bank field of the first mapped word, subtracted to get bank 0
localparam pi1_addr_u FIRST_U = FIRSTADDR;

pi1_req_t        stage_q;
pi1_addr_u       stage_a;
logic [BW-1:0]   bank_idx;
logic            stage_vld;
logic            dflt;
logic            sel_rdy;
logic            done;
logic [NB-1:0]   bank_act;

// request stage
// payload follows the master whenever the stage can move, op alone is reset
always_ff @(posedge clk_i) begin
	if (rdy_o)
		stage_q <= req_i;
	if (!rst_n_i)
		stage_q.op <= NONE;
end

// address decode of the held request
always_comb begin
	stage_a.flat = stage_q.addr;
	stage_vld = (stage_q.op != NONE);
	// flat compare against the map
	dflt = (stage_a.flat < FIRSTADDR) || (stage_a.flat > LASTADDR);
	// bank field relative to bank 0, wraps since the map is bank aligned
	bank_idx = stage_a.field.bank - FIRST_U.field.bank;
	// default slave is always ready
	sel_rdy = dflt || bank_rsp_i[bank_idx].rdy;
	done = stage_vld && sel_rdy;
end

// empty stage or a stage that finishes this edge can take the next op
assign rdy_o = !stage_vld || done;

// steer to one bank, the rest see NONE
always_comb begin
	for (int i = 0; i < NB; i++) begin
		bank_req_o[i] = stage_q;
		if (!(stage_vld && !dflt && (bank_idx == BW'(i))))
			bank_req_o[i].op = NONE;
	end
end

// tag goes out on the edge where the access takes place
always_comb begin
	tag_o.rd = (stage_q.op == READ) || (stage_q.op == RDWR);
	tag_o.bank = bank_idx;
	tag_o.dflt = dflt;
end
assign tag_vld_o = done;

// error pulse follows a default-slave access by one edge
always_ff @(posedge clk_i) begin
	if (!rst_n_i)
		err_o <= 1'b0;
	else
		err_o <= done && dflt;
end

// activity seen at the bank ports
always_comb begin
	for (int i = 0; i < NB; i++)
		bank_act[i] = (bank_req_o[i].op != NONE);
end

// never more than one bank addressed at a time
a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	$onehot0(bank_act));

endmodule

`default_nettype wire

// ==== design/smem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one PerInt scratch-memory bank with byte selects
// the word index is the offset field of the address, so WORDS must not
// exceed PI1R_BANKWORDS; contents start at zero and have no reset
// DELAY 0 takes an operation every cycle, DELAY n holds rdy low n cycles
// and then performs the access on the edge where rdy returns high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "pi1r_params.svh"

module smem import pi1r_pkg::*; #(
	parameter int DELAY = 0,
	parameter int WORDS = `PI1R_BANKWORDS
) (
	input  wire logic     clk_i,
	input  wire logic     rst_n_i,
	input  wire pi1_req_t req_i,
	output pi1_rsp_t      rsp_o
);

// countdown holds at most DELAY-1
localparam int CNTW = (DELAY < 2) ? 1 : $clog2(DELAY);

logic [`PI1R_ARCHBITSZ-1:0] mem [WORDS];
logic [`PI1R_ARCHBITSZ-1:0] rdata_q;
pi1_addr_u                  addr_w;
logic [CNTW-1:0]            cnt_q;
logic                       armed_q;
logic                       req_vld;
logic                       rdy_w;
logic                       access;

initial begin
	for (int i = 0; i < WORDS; i++)
		mem[i] = '0;
end

always_comb begin
	addr_w.flat = req_i.addr;
	req_vld = (req_i.op != NONE);
	// a fresh request drops rdy at once when latency is added
	if (armed_q)
		rdy_w = (cnt_q == '0);
	else
		rdy_w = !((DELAY != 0) && req_vld);
	access = req_vld && rdy_w;
end

// latency countdown
always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		armed_q <= 1'b0;
		cnt_q <= '0;
	end else if (armed_q) begin
		if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
		else
			armed_q <= 1'b0;
	end else if ((DELAY != 0) && req_vld) begin
		// first low cycle is the current one
		armed_q <= 1'b1;
		cnt_q <= CNTW'(DELAY - 1);
	end
end

// word access, old value is captured before the byte merge lands
always_ff @(posedge clk_i) begin
	if (access) begin
		if ((req_i.op == READ) || (req_i.op == RDWR))
			rdata_q <= mem[addr_w.field.offset];
		if ((req_i.op == WRITE) || (req_i.op == RDWR)) begin
			for (int b = 0; b < `PI1R_SELBITSZ; b++) begin
				if (req_i.sel[b])
					mem[addr_w.field.offset][b*8 +: 8] <= req_i.data[b*8 +: 8];
			end
		end
	end
end

// read data holds until the next read of this bank
assign rsp_o.data = rdata_q;
assign rsp_o.rdy = rdy_w;

// stores must touch at least one byte
a_sel_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	((req_i.op == WRITE) || (req_i.op == RDWR)) |-> (req_i.sel != '0));

// the decoder must hold the request while this bank stalls
a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	!rdy_w |=> $stable(req_i));

endmodule

`default_nettype wire

// ==== design/pi1r_collect.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PerInt read-data return path for the master
// the tag arrives on the edge of the bank access, data_o loads one edge
// later and holds until the next read result; writes leave it unchanged
// default-slave reads load zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "pi1r_params.svh"

module pi1r_collect import pi1r_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   rst_n_i,
	input  wire pi1_rsp_t               bank_rsp_i [`PI1R_BANKCOUNT],
	input  wire pi1_tag_t               tag_i,
	input  wire logic                   tag_vld_i,
	output logic [`PI1R_ARCHBITSZ-1:0]  data_o
);

pi1_tag_t tag_q;
logic     pend_q;

// tag of the access that just happened
always_ff @(posedge clk_i) begin
	if (tag_vld_i)
		tag_q <= tag_i;
end

// one cycle behind the bank, so its read register is valid here
always_ff @(posedge clk_i) begin
	if (!rst_n_i)
		pend_q <= 1'b0;
	else
		pend_q <= tag_vld_i;
end

// master read data
always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		data_o <= '0;
	end else if (pend_q && tag_q.rd) begin
		if (tag_q.dflt)
			data_o <= '0;
		else
			data_o <= bank_rsp_i[tag_q.bank].data;
	end
end

// a tag is only issued once the addressed bank takes the access
a_bank_rdy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	(tag_vld_i && !tag_i.dflt) |-> bank_rsp_i[tag_i.bank].rdy);

endmodule

`default_nettype wire

// ==== design/perint_subsys.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PerInt memory subsystem, one master port in front of the scratch banks
// banks run with no added latency, so a read shows on data_o two edges
// after it is accepted and err_o pulses one edge after an unmapped access
// bank count and map come from pi1r_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "pi1r_params.svh"

module perint_subsys import pi1r_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   rst_n_i,
	input  wire pi1_req_t               req_i,
	output logic [`PI1R_ARCHBITSZ-1:0]  data_o,
	output logic                        rdy_o,
	output logic                        err_o
);

// decoder to banks and banks to collector
pi1_req_t bank_req [`PI1R_BANKCOUNT];
pi1_rsp_t bank_rsp [`PI1R_BANKCOUNT];
// per-operation bookkeeping for the return path
pi1_tag_t tag;
logic     tag_vld;

pi1r_decode u_decode (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.req_i      (req_i),
	.bank_rsp_i (bank_rsp),
	.bank_req_o (bank_req),
	.tag_o      (tag),
	.tag_vld_o  (tag_vld),
	.rdy_o      (rdy_o),
	.err_o      (err_o)
);

// one 4 KB bank per slot of the map
for (genvar i = 0; i < `PI1R_BANKCOUNT; i++) begin : g_bank
	smem #(
		.DELAY (0),
		.WORDS (`PI1R_BANKWORDS)
	) u_bank (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (bank_req[i]),
		.rsp_o   (bank_rsp[i])
	);
end

pi1r_collect u_collect (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.bank_rsp_i (bank_rsp),
	.tag_i      (tag),
	.tag_vld_i  (tag_vld),
	.data_o     (data_o)
);

endmodule

`default_nettype wire

// ==== testbench/tb_perint_subsys.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the PerInt memory subsystem with banks at DELAY 0
// inputs change and outputs are sampled on the falling edge
// read data lands two edges and err_o one edge after acceptance
// data_o is then expected to hold until the next read result
// the reference model covers only the mapped span of all banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "pi1r_params.svh"

module tb_perint_subsys import pi1r_pkg::*; ();

localparam int AW = `PI1R_ADDRBITSZ;
localparam int DW = `PI1R_ARCHBITSZ;
localparam int SW = `PI1R_SELBITSZ;
localparam int SPAN = `PI1R_BANKCOUNT * `PI1R_BANKWORDS;
localparam logic [AW-1:0] FIRST = AW'(`PI1R_FIRSTADDR);
localparam logic [AW-1:0] LAST = AW'(`PI1R_LASTADDR);
localparam int RDY_TIMEOUT = 100;
localparam int DRAIN_TIMEOUT = 50;

// model answer for one operation
typedef struct packed {
	logic [DW-1:0] data;
	logic          err;
} ref_res_t;

// one accepted operation waiting for its checks
typedef struct packed {
	logic [31:0]   err_at;
	logic [31:0]   data_at;
	logic          rd;
	logic          err;
	logic [DW-1:0] data;
} expect_t;

logic          clk_i;
logic          rst_n_i;
pi1_req_t      req_i;
logic [DW-1:0] data_o;
logic          rdy_o;
logic          err_o;

logic [DW-1:0] ref_mem [SPAN];
expect_t       pend [$];
logic [31:0]   rng_state = 32'h8a2e7dd4;
logic [31:0]   cyc = '0;
int            errors = 0;
int            err_mark = 0;
int            tests_ok = 0;
int            tests_bad = 0;
int            test_num = 0;
string         cur_name;

perint_subsys u_dut (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.req_i   (req_i),
	.data_o  (data_o),
	.rdy_o   (rdy_o),
	.err_o   (err_o)
);

initial begin
	clk_i = 1'b0;
	forever #2 clk_i = ~clk_i;
end

// counts rising edges for the processes that run on falling edges
always @(posedge clk_i)
	cyc <= cyc + 1;

// xorshift32 never returns zero for a nonzero seed
function automatic logic [31:0] rand_word();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic logic [AW-1:0] rand_addr();
	return FIRST + AW'(rand_word() % 32'(SPAN));
endfunction

// stores need at least one byte lane
function automatic logic [SW-1:0] rand_sel();
	logic [SW-1:0] s;
	s = SW'(rand_word());
	if (s == '0)
		s = SW'(1);
	return s;
endfunction

// mapped word that shares the bank and offset bits of an address
function automatic logic [AW-1:0] mapped_alias(logic [AW-1:0] addr);
	return FIRST + ((addr - FIRST) & AW'(SPAN - 1));
endfunction

// applies one operation to the model with old word out and merged bytes in
function automatic ref_res_t ref_apply(pi1_op_t op, logic [AW-1:0] addr,
	logic [DW-1:0] data, logic [SW-1:0] sel);
	ref_res_t res;
	int       idx;
	res.data = '0;
	res.err = 1'b0;
	// unmapped addresses change nothing
	if ((addr < FIRST) || (addr > LAST)) begin
		res.err = 1'b1;
		return res;
	end
	idx = int'(addr - FIRST);
	if ((op == READ) || (op == RDWR))
		res.data = ref_mem[idx];
	if ((op == WRITE) || (op == RDWR)) begin
		for (int b = 0; b < SW; b++) begin
			if (sel[b])
				ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
		end
	end
	return res;
endfunction

task automatic flag_mismatch(string sig, logic [DW-1:0] got, logic [DW-1:0] exp);
	$display("ERROR %s got %h expected %h at cycle %0d", sig, got, exp, cyc);
	errors++;
endtask

// drives one operation and returns on the edge that accepts it
task automatic do_op(pi1_op_t op, logic [AW-1:0] addr, logic [DW-1:0] data,
	logic [SW-1:0] sel);
	int       waited;
	ref_res_t res;
	expect_t  e;
	@(negedge clk_i);
	req_i = '{op: op, addr: addr, data: data, sel: sel};
	waited = 0;
	while (!rdy_o && (waited < RDY_TIMEOUT)) begin
		@(negedge clk_i);
		waited++;
	end
	if (!rdy_o) begin
		$display("rdy_o stayed low for %0d cycles in %s", waited, cur_name);
		$display("Some tests failed");
		$finish;
	end else begin
		res = ref_apply(op, addr, data, sel);
		// accepted at the next edge with err one edge later and data two
		e.err_at = cyc + 2;
		e.data_at = cyc + 3;
		e.rd = (op == READ) || (op == RDWR);
		e.err = res.err;
		e.data = res.data;
		pend.push_back(e);
		@(posedge clk_i);
	end
endtask

// idles the port until every pending check has run
task automatic drain();
	int waited;
	@(negedge clk_i);
	req_i.op = NONE;
	waited = 0;
	while ((pend.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
		@(negedge clk_i);
		waited++;
	end
	if (pend.size() != 0) begin
		$display("%0d results never checked in %s", pend.size(), cur_name);
		$display("Some tests failed");
		$finish;
	end
endtask

task automatic start_test(string name);
	test_num++;
	cur_name = name;
	err_mark = errors;
endtask

task automatic finish_test();
	drain();
	if (errors == err_mark) begin
		tests_ok++;
		$display("test %0d %s: ok", test_num, cur_name);
	end else begin
		tests_bad++;
		$display("test %0d %s: FAILED with %0d errors", test_num, cur_name, errors - err_mark);
	end
endtask

// err_o and data_o are compared on every falling edge after reset
initial begin : compare
	logic          exp_err;
	logic [DW-1:0] exp_data;
	exp_data = '0;
	forever begin
		@(negedge clk_i);
		exp_err = 1'b0;
		foreach (pend[i]) begin
			if ((pend[i].err_at == cyc) && pend[i].err)
				exp_err = 1'b1;
			// a read result lands here and holds until the next one
			if ((pend[i].data_at == cyc) && pend[i].rd)
				exp_data = pend[i].data;
		end
		if (rst_n_i && (err_o !== exp_err))
			flag_mismatch("err_o", DW'(err_o), DW'(exp_err));
		if (rst_n_i && (data_o !== exp_data))
			flag_mismatch("data_o", data_o, exp_data);
		while ((pend.size() != 0) && (pend[0].data_at <= cyc))
			void'(pend.pop_front());
	end
end

initial begin : main
	logic [AW-1:0] a;
	logic [31:0]   r;
	pi1_op_t       op;
	rst_n_i = 1'b0;
	req_i = '0;
	for (int i = 0; i < SPAN; i++)
		ref_mem[i] = '0;
	repeat (8) @(negedge clk_i);
	rst_n_i = 1'b1;

	start_test("reset state");
	@(negedge clk_i);
	if (rdy_o !== 1'b1)
		flag_mismatch("rdy_o", DW'(rdy_o), DW'(1));
	if (err_o !== 1'b0)
		flag_mismatch("err_o", DW'(err_o), DW'(0));
	if (data_o !== '0)
		flag_mismatch("data_o", data_o, '0);
	for (int b = 0; b < `PI1R_BANKCOUNT; b++)
		do_op(READ, FIRST + AW'(b * `PI1R_BANKWORDS), '0, '0);
	finish_test();

	start_test("word write and read per bank");
	for (int b = 0; b < `PI1R_BANKCOUNT; b++) begin
		// first, middle and last word of the bank
		for (int k = 0; k < 3; k++) begin
			a = FIRST + AW'(b * `PI1R_BANKWORDS + k * (`PI1R_BANKWORDS / 2));
			if (k == 2)
				a = FIRST + AW'((b + 1) * `PI1R_BANKWORDS - 1);
			do_op(WRITE, a, rand_word(), '1);
			do_op(READ, a, '0, '0);
		end
	end
	finish_test();

	start_test("byte select merge");
	for (int i = 0; i < 24; i++) begin
		a = rand_addr();
		do_op(WRITE, a, rand_word(), '1);
		do_op(WRITE, a, rand_word(), rand_sel());
		do_op(READ, a, '0, '0);
	end
	finish_test();

	start_test("read-write swap");
	for (int i = 0; i < 16; i++) begin
		a = rand_addr();
		do_op(RDWR, a, rand_word(), rand_sel());
		do_op(READ, a, '0, '0);
	end
	finish_test();

	start_test("back-to-back random ops");
	for (int i = 0; i < 200; i++) begin
		r = rand_word();
		case (r[1:0])
			2'd1: op = WRITE;
			2'd3: op = RDWR;
			default: op = READ;
		endcase
		do_op(op, rand_addr(), rand_word(), rand_sel());
	end
	finish_test();

	start_test("unmapped accesses");
	// just outside both ends and then random unmapped words
	do_op(WRITE, FIRST - 1'b1, rand_word(), '1);
	do_op(READ, FIRST - 1'b1, '0, '0);
	do_op(READ, mapped_alias(FIRST - 1'b1), '0, '0);
	do_op(RDWR, LAST + 1'b1, rand_word(), '1);
	do_op(READ, LAST + 1'b1, '0, '0);
	do_op(WRITE, '0, rand_word(), '1);
	do_op(READ, '1, '0, '0);
	for (int i = 0; i < 12; i++) begin
		a = AW'(rand_word());
		if ((a >= FIRST) && (a <= LAST))
			a = a + AW'(SPAN);
		op = WRITE;
		if ((i % 2) != 0)
			op = RDWR;
		do_op(op, a, rand_word(), rand_sel());
		// the mapped word with the same bank and offset bits is untouched
		do_op(READ, mapped_alias(a), '0, '0);
	end
	// mapped words must still hold what the model has
	for (int b = 0; b < `PI1R_BANKCOUNT; b++)
		do_op(READ, FIRST + AW'(b * `PI1R_BANKWORDS), '0, '0);
	for (int i = 0; i < 16; i++)
		do_op(READ, rand_addr(), '0, '0);
	finish_test();

	$display("tests run %0d, ok %0d, failed %0d, check errors %0d",
		test_num, tests_ok, tests_bad, errors);
	if ((tests_bad == 0) && (errors == 0))
		$display("All tests passed");
	else
		$display("Some tests failed");
	$finish;
end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
design/pi1r_pkg.sv
design/pi1r_decode.sv
design/smem.sv
design/pi1r_collect.sv
design/perint_subsys.sv
testbench/tb_perint_subsys.sv

// ==== Makefile ====
# Verilator build and run for the PerInt memory subsystem

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_perint_subsys
FILELIST = project.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard design/*.sv) $(wildcard testbench/*.sv)
HDRS     = $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
